//--- Bender.yml
package:
  name: echo_dma

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/echo_dma_pkg.sv
      - verilog/csr_decode.sv
      - verilog/copy_mover.sv
      - verilog/completion_irq.sv
      - verilog/echo_dma_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_clkgen.sv
      - verif/tb_echo_dma.sv

//--- echo_dma.f
+incdir+verilog
verilog/echo_dma_pkg.sv
verilog/csr_decode.sv
verilog/copy_mover.sv
verilog/completion_irq.sv
verilog/echo_dma_top.sv
verif/tb_clkgen.sv
verif/tb_echo_dma.sv

//--- verif/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1; // released on a falling edge
    end

endmodule

`default_nettype wire

//--- verif/tb_echo_dma.sv
`timescale 1ns/1ns
`default_nettype none
`include "echo_dma_defines.svh"

module tb_echo_dma;

    localparam int          NUM_RUNS  = 6;
    localparam logic [63:0] SRC_XOR   = 64'h5a3c_96e1_0f0f_c3a5;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        logic [1:0]  code;
        logic [31:0] total;
        logic [63:0] base;
        logic [7:0]  bursts; // expected write commands
        logic        stall;  // random ready stalls on all channels
    } run_row_t;

    // destination ranges do not overlap, so a rewritten word shows up as a duplicate
    run_row_t runs [NUM_RUNS] = '{
        '{2'd0, 32'd256,  64'h0000_0001_0000_0000, 8'd2, 1'b0},
        '{2'd1, 32'd1000, 64'h0000_0000_0000_2000, 8'd4, 1'b0},
        '{2'd2, 32'd1536, 64'hffff_0000_0000_1000, 8'd3, 1'b1},
        '{2'd0, 32'd300,  64'h0000_0000_8000_0000, 8'd3, 1'b1},
        '{2'd1, 32'd64,   64'h0000_0000_0000_0040, 8'd1, 1'b1},
        '{2'd3, 32'd512,  64'h0000_0000_0000_0100, 8'd0, 1'b0}  // reserved code
    };

    logic                    clk;
    logic                    rstn;
    logic [1:0]              cfg_max_payload = 2'd0;
    echo_dma_pkg::wb_req_t   wb_req          = '0;
    logic                    rd_cmd_ready    = 1'b0;
    logic                    wr_cmd_ready    = 1'b0;
    echo_dma_pkg::mem_beat_t rd_beat         = '0;
    logic                    wr_beat_ready   = 1'b0;
    logic                    wr_done         = 1'b0;
    logic                    wb_ack;
    logic [31:0]             wb_dat_r;
    echo_dma_pkg::mem_cmd_t  rd_cmd;
    echo_dma_pkg::mem_cmd_t  wr_cmd;
    logic                    rd_beat_ready;
    echo_dma_pkg::mem_beat_t wr_beat;
    logic                    irq;

    logic       stall     = 1'b0; // set by the main process
    logic [2:0] exp_len   = '0;
    int         main_errs = 0;

    // memory model state, owned by the posedge monitor
    echo_dma_pkg::mem_cmd_t src_q[$];
    echo_dma_pkg::mem_cmd_t dst_q[$];
    int          src_idx      = 0;
    int          dst_idx      = 0;
    int          done_pending = 0;
    int          ack_count    = 0;
    int          irq_count    = 0;
    int          rd_cmd_count = 0;
    int          wr_cmd_count = 0;
    int          beat_count   = 0;
    int          done_count   = 0;
    int          mon_errs     = 0;
    logic [63:0] dest_mem [logic [63:0]];
    logic [63:0] wr_addr;

    logic [31:0] lfsr = 32'hd7ce; // stepped only by the negedge driver
    logic        beat_fired;

    tb_clkgen i_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    echo_dma_top i_dut (
        .clk             (clk),
        .rstn            (rstn),
        .cfg_max_payload (cfg_max_payload),
        .wb_req          (wb_req),
        .rd_cmd_ready    (rd_cmd_ready),
        .wr_cmd_ready    (wr_cmd_ready),
        .rd_beat         (rd_beat),
        .wr_beat_ready   (wr_beat_ready),
        .wr_done         (wr_done),
        .wb_ack          (wb_ack),
        .wb_dat_r        (wb_dat_r),
        .rd_cmd          (rd_cmd),
        .wr_cmd          (wr_cmd),
        .rd_beat_ready   (rd_beat_ready),
        .wr_beat         (wr_beat),
        .irq             (irq)
    );

    function automatic void report_mismatch(input string what, input logic [63:0] got,
                                            input logic [63:0] exp);
        $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endfunction

    // galois lfsr stepped once per bit
    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        return b;
    endfunction

    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int acks_before;
        int waited;
        @(negedge clk);
        acks_before  = ack_count;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdat;
        wb_req.sel   = 4'hf;
        waited       = 0;
        @(negedge clk);
        while (!wb_ack && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        rdat = wb_dat_r;
        if (!wb_ack) begin
            $display("register access at 0x%0h was never acknowledged", adr);
            main_errs++;
        end
        wb_req = '0; // drop stb after ack
        repeat (2) @(negedge clk); // one edge more to catch a stretched ack
        if (ack_count - acks_before != 1) begin
            report_mismatch("ack count of one access", 64'(ack_count - acks_before), 64'd1);
            main_errs++;
        end
    endtask

    task automatic write_reg(input logic [7:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic read_reg(input logic [7:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'h0, rdat);
    endtask

    // memory models drive on the falling edge
    always @(negedge clk) begin
        beat_fired   = rd_beat.valid && rd_beat_ready; // handshake at the last rising edge
        rd_cmd_ready = stall ? take_bit() : 1'b1;
        wr_cmd_ready = stall ? take_bit() : 1'b1;
        if (!rd_beat.valid || beat_fired) begin
            rd_beat.valid = (src_q.size() > 0) && (stall ? take_bit() : 1'b1);
            rd_beat.data  = '0;
            rd_beat.last  = 1'b0;
            if (rd_beat.valid) begin
                rd_beat.data = (src_q[0].addr + 64'(8 * src_idx)) ^ SRC_XOR;
                rd_beat.last = (src_idx == int'(src_q[0].len));
            end
        end
        wr_beat_ready = (dst_q.size() > 0) && (stall ? take_bit() : 1'b1);
        wr_done       = (done_pending > 0) && (stall ? take_bit() : 1'b1);
    end

    always @(posedge clk) begin
        if (irq) begin
            irq_count++;
            if (done_count != wr_cmd_count) begin
                $display("irq raised at %0t before every write burst completed", $time);
                mon_errs++;
            end
        end
        if (wb_ack) ack_count++;
        if (rd_cmd.valid && rd_cmd_ready) begin
            rd_cmd_count++;
            if (rd_cmd.len !== exp_len) begin
                report_mismatch("read command len", 64'(rd_cmd.len), 64'(exp_len));
                mon_errs++;
            end
            src_q.push_back(rd_cmd);
        end
        if (wr_cmd.valid && wr_cmd_ready) begin
            wr_cmd_count++;
            if (wr_cmd.len !== exp_len) begin
                report_mismatch("write command len", 64'(wr_cmd.len), 64'(exp_len));
                mon_errs++;
            end
            dst_q.push_back(wr_cmd);
        end
        if (rd_beat.valid && rd_beat_ready) begin
            if (src_idx == int'(src_q[0].len)) begin
                void'(src_q.pop_front());
                src_idx = 0;
            end else begin
                src_idx++;
            end
        end
        if (wr_beat.valid && wr_beat_ready) begin
            wr_addr = dst_q[0].addr + 64'(8 * dst_idx);
            if (dest_mem.exists(wr_addr)) begin
                $display("destination word at %0h written twice", wr_addr);
                mon_errs++;
            end
            dest_mem[wr_addr] = wr_beat.data;
            beat_count++;
            if (wr_beat.last !== (dst_idx == int'(dst_q[0].len))) begin
                report_mismatch("write beat last", 64'(wr_beat.last),
                                64'(dst_idx == int'(dst_q[0].len)));
                mon_errs++;
            end
            if (dst_idx == int'(dst_q[0].len)) begin
                void'(dst_q.pop_front());
                dst_idx = 0;
                done_pending++; // completion follows the final beat
            end else begin
                dst_idx++;
            end
        end
        if (wr_done) begin
            done_pending--;
            done_count++;
        end
    end

    // limit scales with the bytes the table moves
    initial begin : watchdog
        int total_sum;
        int limit;
        total_sum = 0;
        for (int i = 0; i < NUM_RUNS; i++) begin
            total_sum += int'(runs[i].total);
        end
        limit = 4 * total_sum + 400 * NUM_RUNS;
        repeat (limit) @(posedge clk);
        $display("timeout: the runs did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        run_row_t    row;
        int          errs_before;
        int          irq0;
        int          rd0;
        int          wr0;
        int          beats0;
        int          burst_bytes;
        int          beats;
        int          off;
        int          passed;
        int          failed;
        logic [31:0] rdat;
        logic [63:0] addr;
        passed = 0;
        failed = 0;
        wait (rstn === 1'b1);
        for (int r = 0; r < NUM_RUNS; r++) begin
            row         = runs[r];
            errs_before = main_errs + mon_errs;
            @(negedge clk);
            cfg_max_payload = row.code;
            stall           = row.stall;
            exp_len         = 3'((2 << row.code) - 1);
            burst_bytes     = 128 << row.code;
            beats           = 2 << row.code; // 64-bit beats per burst
            irq0            = irq_count;
            rd0             = rd_cmd_count;
            wr0             = wr_cmd_count;
            beats0          = beat_count;
            write_reg(`ECHO_REG_BASE_LO, row.base[31:0]);
            write_reg(`ECHO_REG_BASE_HI, row.base[63:32]);
            write_reg(`ECHO_REG_TOTAL, row.total);
            read_reg(`ECHO_REG_BASE_LO, rdat);
            if (rdat !== row.base[31:0]) begin
                report_mismatch("BASE_LO readback", 64'(rdat), 64'(row.base[31:0]));
                main_errs++;
            end
            read_reg(`ECHO_REG_BASE_HI, rdat);
            if (rdat !== row.base[63:32]) begin
                report_mismatch("BASE_HI readback", 64'(rdat), 64'(row.base[63:32]));
                main_errs++;
            end
            read_reg(`ECHO_REG_TOTAL, rdat);
            if (rdat !== row.total) begin
                report_mismatch("TOTAL readback", 64'(rdat), 64'(row.total));
                main_errs++;
            end
            write_reg(`ECHO_REG_START, 32'h1);
            if (row.code != 2'd3) begin
                read_reg(`ECHO_REG_START, rdat);
                if (rdat !== 32'h1) begin
                    report_mismatch("START readback", 64'(rdat), 64'd1);
                    main_errs++;
                end
                while (irq_count == irq0) @(negedge clk);
                repeat (20) @(negedge clk); // room for a stray second pulse
                if (irq_count - irq0 != 1) begin
                    report_mismatch("irq pulses", 64'(irq_count - irq0), 64'd1);
                    main_errs++;
                end
                if (wr_cmd_count - wr0 != int'(row.bursts)) begin
                    report_mismatch("write commands", 64'(wr_cmd_count - wr0), 64'(row.bursts));
                    main_errs++;
                end
                if (rd_cmd_count - rd0 != int'(row.bursts)) begin
                    report_mismatch("read commands", 64'(rd_cmd_count - rd0), 64'(row.bursts));
                    main_errs++;
                end
                if (beat_count - beats0 != int'(row.bursts) * beats) begin
                    report_mismatch("beats written", 64'(beat_count - beats0),
                                    64'(int'(row.bursts) * beats));
                    main_errs++;
                end
                // each burst starts at its byte offset and fills beats words from there
                for (int b = 0; b < int'(row.bursts); b++) begin
                    for (int i = 0; i < beats; i++) begin
                        off  = b * burst_bytes + 8 * i;
                        addr = row.base + 64'(off);
                        if (!dest_mem.exists(addr)) begin
                            $display("destination word at %0h was never written", addr);
                            main_errs++;
                        end else if (dest_mem[addr] !== (64'(off) ^ SRC_XOR)) begin
                            report_mismatch("destination word", dest_mem[addr],
                                            64'(off) ^ SRC_XOR);
                            main_errs++;
                        end
                    end
                end
                read_reg(`ECHO_REG_STATUS, rdat);
                if (rdat[1:0] !== 2'b01) begin
                    report_mismatch("STATUS after run", 64'(rdat[1:0]), 64'd1);
                    main_errs++;
                end
            end else begin
                repeat (row.total / 8 * 4) @(negedge clk);
                if (rd_cmd_count != rd0 || wr_cmd_count != wr0) begin
                    $display("reserved payload code issued memory commands");
                    main_errs++;
                end
                if (irq_count != irq0) begin
                    $display("reserved payload code raised an interrupt");
                    main_errs++;
                end
                read_reg(`ECHO_REG_STATUS, rdat);
                if (rdat[`ECHO_STS_ERR] !== 1'b1) begin
                    report_mismatch("STATUS error bit", 64'(rdat[`ECHO_STS_ERR]), 64'd1);
                    main_errs++;
                end
            end
            if (main_errs + mon_errs == errs_before) begin
                passed++;
                $display("run %0d (code %0d, %0d bytes, stall %0d): passed",
                         r, row.code, row.total, row.stall);
            end else begin
                failed++;
                $display("run %0d (code %0d, %0d bytes, stall %0d): failed, %0d errors",
                         r, row.code, row.total, row.stall, main_errs + mon_errs - errs_before);
            end
        end
        $display("%0d runs, %0d passed, %0d failed, %0d errors",
                 NUM_RUNS, passed, failed, main_errs + mon_errs);
        if (failed == 0 && main_errs + mon_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/completion_irq.sv
`timescale 1ns/1ns
`default_nettype none
`include "echo_dma_defines.svh"

module completion_irq (
    input  logic                    clk,
    input  logic                    rstn,
    input  echo_dma_pkg::echo_cfg_t cfg,
    input  logic                    wr_cmd_fire,
    input  logic                    wr_done,
    input  logic                    issue_done,
    output logic                    irq,
    output logic                    done
);

    logic        start_d;
    logic        start_rise;
    logic        armed;        // run in flight, irq still owed
    logic [15:0] outstanding;  // write bursts accepted but not completed

    assign start_rise = cfg.start & ~start_d;
    assign irq        = armed & issue_done & (outstanding == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            start_d     <= 1'b0;
            outstanding <= '0;
        end else begin
            start_d <= cfg.start;
            case ({wr_cmd_fire, wr_done})
                2'b10:   outstanding <= outstanding + 16'd1;
                2'b01:   outstanding <= outstanding - 16'd1;
                default: ; // both or neither, count unchanged
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            armed <= 1'b0;
            done  <= 1'b0;
        end else if (start_rise) begin
            armed <= 1'b1;
            done  <= 1'b0;
        end else if (irq) begin
            armed <= 1'b0; // one pulse per run
            done  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/copy_mover.sv
`timescale 1ns/1ns
`default_nettype none
`include "echo_dma_defines.svh"

module copy_mover (
    input  logic                    clk,
    input  logic                    rstn,
    input  echo_dma_pkg::echo_cfg_t cfg,
    input  logic [1:0]              cfg_max_payload,
    input  logic                    rd_cmd_ready,
    input  logic                    wr_cmd_ready,
    input  echo_dma_pkg::mem_beat_t rd_beat,
    input  logic                    wr_beat_ready,
    output echo_dma_pkg::mem_cmd_t  rd_cmd,
    output echo_dma_pkg::mem_cmd_t  wr_cmd,
    output logic                    rd_beat_ready,
    output echo_dma_pkg::mem_beat_t wr_beat,
    output logic                    issue_done
);

    echo_dma_pkg::mover_state_e state, state_next;
    logic                   start_d;
    logic                   start_rise;
    logic                   pair_done;  // last of the two commands taken
    logic                   can_run;
    logic                   more;
    logic [31:0]            offset;     // bytes issued so far
    logic [32:0]            next_offset;
    logic [`ECHO_LEN_W-1:0] len_q;
    logic [9:0]             burst_bytes;

    assign start_rise  = cfg.start & ~start_d;
    assign next_offset = {1'b0, offset} + 33'(burst_bytes);
    assign more        = next_offset < {1'b0, cfg.total_bytes};
    assign can_run     = (cfg.total_bytes != '0) && (burst_bytes != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            len_q       <= '0;
            burst_bytes <= '0;
        end else begin
            case (cfg_max_payload)
                2'b00: begin
                    len_q       <= 3'd1;
                    burst_bytes <= `ECHO_BURST_128;
                end
                2'b01: begin
                    len_q       <= 3'd3;
                    burst_bytes <= `ECHO_BURST_256;
                end
                2'b10: begin
                    len_q       <= 3'd7;
                    burst_bytes <= `ECHO_BURST_512;
                end
                default: begin // reserved, nothing moves
                    len_q       <= '0;
                    burst_bytes <= '0;
                end
            endcase
        end
    end

    always_comb begin
        state_next = state;
        pair_done  = 1'b0;
        case (state)
            echo_dma_pkg::mv_idle, echo_dma_pkg::mv_finished:
                if (start_rise) begin
                    state_next = can_run ? echo_dma_pkg::mv_issue_both
                                         : echo_dma_pkg::mv_finished;
                end
            echo_dma_pkg::mv_issue_both:
                if (rd_cmd_ready && wr_cmd_ready) begin
                    pair_done = 1'b1;
                end else if (rd_cmd_ready) begin
                    state_next = echo_dma_pkg::mv_issue_wr;
                end else if (wr_cmd_ready) begin
                    state_next = echo_dma_pkg::mv_issue_rd;
                end
            echo_dma_pkg::mv_issue_rd:
                pair_done = rd_cmd_ready;
            echo_dma_pkg::mv_issue_wr:
                pair_done = wr_cmd_ready;
            default:
                state_next = echo_dma_pkg::mv_idle;
        endcase
        if (pair_done) begin
            state_next = more ? echo_dma_pkg::mv_issue_both : echo_dma_pkg::mv_finished;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= echo_dma_pkg::mv_idle;
            start_d <= 1'b0;
            offset  <= '0;
        end else begin
            state   <= state_next;
            start_d <= cfg.start;
            if (start_rise && (state == echo_dma_pkg::mv_idle ||
                               state == echo_dma_pkg::mv_finished)) begin
                offset <= '0; // every run starts at offset zero
            end else if (pair_done) begin
                offset <= next_offset[31:0];
            end
        end
    end

    assign issue_done = (state == echo_dma_pkg::mv_finished);

    // read side uses the bare offset, write side adds the base
    assign rd_cmd.valid = (state == echo_dma_pkg::mv_issue_both) ||
                          (state == echo_dma_pkg::mv_issue_rd);
    assign rd_cmd.addr  = `ECHO_ADDR_W'(offset);
    assign rd_cmd.len   = len_q;

    assign wr_cmd.valid = (state == echo_dma_pkg::mv_issue_both) ||
                          (state == echo_dma_pkg::mv_issue_wr);
    assign wr_cmd.addr  = cfg.dst_base + `ECHO_ADDR_W'(offset);
    assign wr_cmd.len   = len_q;

    assign wr_beat       = rd_beat;       // beats go straight across
    assign rd_beat_ready = wr_beat_ready; // write stall holds the read side

endmodule

`default_nettype wire

//--- verilog/csr_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "echo_dma_defines.svh"

module csr_decode (
    input  logic                      clk,
    input  logic                      rstn,
    input  echo_dma_pkg::wb_req_t     wb_req,
    input  logic [1:0]                cfg_max_payload,
    input  logic                      done,
    output logic                      wb_ack,
    output logic [`ECHO_WB_DAT_W-1:0] wb_dat_r,
    output echo_dma_pkg::echo_cfg_t   cfg,
    output logic                      payload_err
);

    logic                      req_new;   // active and not yet acked
    logic                      start_wr;
    logic                      restart;
    echo_dma_pkg::csr_addr_e   reg_idx;
    logic [`ECHO_ADDR_W-1:0]   base_q;
    logic [31:0]               total_q;
    logic                      start_q;
    logic [`ECHO_WB_DAT_W-1:0] rd_val;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = sel[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
        end
        return res;
    endfunction

    assign req_new     = wb_req.cyc & wb_req.stb & ~wb_ack;
    assign reg_idx     = echo_dma_pkg::csr_addr_e'(wb_req.adr[`ECHO_WB_ADR_W-1:2]);
    assign payload_err = (cfg_max_payload == 2'b11); // reserved code
    assign start_wr    = req_new & wb_req.we & (reg_idx == echo_dma_pkg::csr_start);

    // new run after a finished one, start dips low for the request cycle
    // so the mover and irq block see a fresh rising edge on the ack cycle
    assign restart = start_wr & done & ~payload_err;

    assign cfg = '{dst_base: base_q, total_bytes: total_q, start: start_q & ~restart};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req_new; // one cycle, never back to back
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            base_q  <= '0;
            total_q <= '0;
            start_q <= 1'b0;
        end else if (req_new && wb_req.we) begin
            case (reg_idx)
                echo_dma_pkg::csr_base_lo:
                    base_q[31:0] <= merge_bytes(base_q[31:0], wb_req.dat_w, wb_req.sel);
                echo_dma_pkg::csr_base_hi:
                    base_q[63:32] <= merge_bytes(base_q[63:32], wb_req.dat_w, wb_req.sel);
                echo_dma_pkg::csr_total:
                    total_q <= merge_bytes(total_q, wb_req.dat_w, wb_req.sel);
                echo_dma_pkg::csr_start:
                    if (!payload_err) start_q <= 1'b1; // sticky
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_idx)
            echo_dma_pkg::csr_base_lo: rd_val = base_q[31:0];
            echo_dma_pkg::csr_base_hi: rd_val = base_q[63:32];
            echo_dma_pkg::csr_total:   rd_val = total_q;
            echo_dma_pkg::csr_start:   rd_val = {31'b0, start_q};
            echo_dma_pkg::csr_status: begin
                rd_val = '0;
                rd_val[`ECHO_STS_DONE] = done;
                rd_val[`ECHO_STS_ERR]  = payload_err;
            end
            default:                   rd_val = '0;
        endcase
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (req_new && !wb_req.we) begin
            wb_dat_r <= rd_val;
        end
    end

endmodule

`default_nettype wire

//--- verilog/echo_dma_defines.svh
`ifndef ECHO_DMA_DEFINES_SVH
`define ECHO_DMA_DEFINES_SVH

// memory side
`define ECHO_DATA_W     64
`define ECHO_ADDR_W     64
`define ECHO_LEN_W      3   // beats minus one, up to 8 beats

// host side
`define ECHO_WB_ADR_W   8
`define ECHO_WB_DAT_W   32
`define ECHO_WB_SEL_W   4
`define ECHO_CSR_IDX_W  6   // word index, adr without the byte bits

// register byte offsets
`define ECHO_REG_BASE_LO  'h00
`define ECHO_REG_BASE_HI  'h04
`define ECHO_REG_TOTAL    'h08
`define ECHO_REG_START    'h0C
`define ECHO_REG_STATUS   'h10

// status bits
`define ECHO_STS_DONE   0
`define ECHO_STS_ERR    1

// burst sizes in bytes per payload code
`define ECHO_BURST_128  128
`define ECHO_BURST_256  256
`define ECHO_BURST_512  512

`endif

//--- verilog/echo_dma_pkg.sv
`default_nettype none
`include "echo_dma_defines.svh"

package echo_dma_pkg;

    // register word index, derived from the byte offsets
    typedef enum logic [`ECHO_CSR_IDX_W-1:0] {
        csr_base_lo = `ECHO_REG_BASE_LO / 4,
        csr_base_hi = `ECHO_REG_BASE_HI / 4,
        csr_total   = `ECHO_REG_TOTAL / 4,
        csr_start   = `ECHO_REG_START / 4,
        csr_status  = `ECHO_REG_STATUS / 4
    } csr_addr_e;

    typedef enum logic [2:0] {
        mv_idle,
        mv_issue_both,  // read and write command both pending
        mv_issue_rd,    // write already taken
        mv_issue_wr,    // read already taken
        mv_finished
    } mover_state_e;

    typedef struct packed {
        logic [`ECHO_ADDR_W-1:0] dst_base;
        logic [31:0]             total_bytes;
        logic                    start;
    } echo_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic [`ECHO_ADDR_W-1:0] addr;
        logic [`ECHO_LEN_W-1:0]  len;
    } mem_cmd_t;

    typedef struct packed {
        logic                    valid;
        logic [`ECHO_DATA_W-1:0] data;
        logic                    last;
    } mem_beat_t;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`ECHO_WB_ADR_W-1:0] adr;
        logic [`ECHO_WB_DAT_W-1:0] dat_w;
        logic [`ECHO_WB_SEL_W-1:0] sel;
    } wb_req_t;

endpackage

`default_nettype wire

//--- verilog/echo_dma_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "echo_dma_defines.svh"

module echo_dma_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [1:0]                cfg_max_payload,
    input  echo_dma_pkg::wb_req_t     wb_req,
    input  logic                      rd_cmd_ready,
    input  logic                      wr_cmd_ready,
    input  echo_dma_pkg::mem_beat_t   rd_beat,
    input  logic                      wr_beat_ready,
    input  logic                      wr_done,
    output logic                      wb_ack,
    output logic [`ECHO_WB_DAT_W-1:0] wb_dat_r,
    output echo_dma_pkg::mem_cmd_t    rd_cmd,
    output echo_dma_pkg::mem_cmd_t    wr_cmd,
    output logic                      rd_beat_ready,
    output echo_dma_pkg::mem_beat_t   wr_beat,
    output logic                      irq
);

    echo_dma_pkg::echo_cfg_t cfg;
    logic                    done;
    logic                    issue_done;
    logic                    wr_cmd_fire;

    assign wr_cmd_fire = wr_cmd.valid & wr_cmd_ready;

    csr_decode i_csr_decode (
        .clk             (clk),
        .rstn            (rstn),
        .wb_req          (wb_req),
        .cfg_max_payload (cfg_max_payload),
        .done            (done),
        .wb_ack          (wb_ack),
        .wb_dat_r        (wb_dat_r),
        .cfg             (cfg),
        .payload_err     ()   // only read back through STATUS
    );

    copy_mover i_copy_mover (
        .clk             (clk),
        .rstn            (rstn),
        .cfg             (cfg),
        .cfg_max_payload (cfg_max_payload),
        .rd_cmd_ready    (rd_cmd_ready),
        .wr_cmd_ready    (wr_cmd_ready),
        .rd_beat         (rd_beat),
        .wr_beat_ready   (wr_beat_ready),
        .rd_cmd          (rd_cmd),
        .wr_cmd          (wr_cmd),
        .rd_beat_ready   (rd_beat_ready),
        .wr_beat         (wr_beat),
        .issue_done      (issue_done)
    );

    completion_irq i_completion_irq (
        .clk         (clk),
        .rstn        (rstn),
        .cfg         (cfg),
        .wr_cmd_fire (wr_cmd_fire),
        .wr_done     (wr_done),
        .issue_done  (issue_done),
        .irq         (irq),
        .done        (done)
    );

endmodule

`default_nettype wire
